// File: design/boot_rom.sv
`timescale 1ns/10ps
`default_nettype none

module boot_rom import bus_pkg::*, periph_pkg::*; (
	input logic      clk,
	input logic      rst_n_i,
	periph_if.periph bus_p
);

	rom_index_t idx;
	bus_data_t  word;

	assign idx = bus_p.offset[5:2];

	// Small boot loop, MIPS encoding
	always_comb begin
		case (idx)
			4'h0: word = 32'h3C08_1000; // lui  t0, RAM base
			4'h1: word = 32'h3409_0055;
			4'h2: word = 32'hAD09_0000;
			4'h3: word = 32'h8D0A_0000;
			4'h4: word = 32'h3C0B_2000; // lui  t3, UART base
			4'h5: word = 32'h240C_0048;
			4'h6: word = 32'hAD6C_0000;
			4'h7: word = 32'h8D6D_0004; // Poll status
			4'h8: word = 32'h31AD_0001;
			4'h9: word = 32'h15A0_FFFD;
			4'hA: word = 32'h0000_0000;
			4'hB: word = 32'h3C0E_3000;
			4'hC: word = 32'h240F_0007;
			4'hD: word = 32'hADCF_0000;
			4'hE: word = 32'h1000_FFFF; // Spin
			default: word = 32'h0000_0000;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			bus_p.done <= 1'b0;
		end else begin
			bus_p.done <= bus_p.req;
		end
	end

	always_ff @(posedge clk) begin
		if (bus_p.req) bus_p.rdata <= word;
	end

	a_no_rom_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		bus_p.req |-> !bus_p.we);

endmodule

`default_nettype wire

// File: design/bus_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bus_ctrl import bus_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      req_valid_i,
	input  bus_addr_t req_addr_i,
	input  logic      req_we_i,
	input  bus_data_t req_wdata_i,
	input  bus_sel_t  req_sel_i,
	input  logic      rsp_ready_i,
	output logic      req_ready_o,
	output logic      rsp_valid_o,
	output bus_data_t rsp_rdata_o,
	output logic      rsp_err_o,
	periph_if.ctrl    rom_p,
	periph_if.ctrl    ram_p,
	periph_if.ctrl    uart_p,
	periph_if.ctrl    seg_p
);

	ctrl_state_t state_q;
	logic [3:0]  req_q; // One-hot pulse, bit order rom/ram/uart/seg
	bus_addr_t   addr_q;
	logic        we_q;
	bus_data_t   wdata_q;
	bus_sel_t    sel_q;
	bus_data_t   rsp_rdata_q;
	logic        rsp_err_q;
	region_t     req_region;
	region_t     cur_region;
	logic [3:0]  region_hit;
	logic        accept;
	logic        done_sel;
	bus_data_t   rdata_sel;
	bus_addr_t   offset;

	assign req_region = req_addr_i[REGION_MSB:REGION_LSB];
	assign cur_region = addr_q[REGION_MSB:REGION_LSB];
	assign accept = req_valid_i && req_ready_o;

	// ROM writes count as a miss
	always_comb begin
		region_hit = '0;
		case (req_region)
			REGION_ROM:  region_hit[0] = !req_we_i;
			REGION_RAM:  region_hit[1] = 1'b1;
			REGION_UART: region_hit[2] = 1'b1;
			REGION_SEG:  region_hit[3] = 1'b1;
			default:     region_hit = '0;
		endcase
	end

	always_comb begin
		case (cur_region)
			REGION_ROM: begin
				done_sel = rom_p.done;
				rdata_sel = rom_p.rdata;
			end
			REGION_RAM: begin
				done_sel = ram_p.done;
				rdata_sel = ram_p.rdata;
			end
			REGION_UART: begin
				done_sel = uart_p.done;
				rdata_sel = uart_p.rdata;
			end
			REGION_SEG: begin
				done_sel = seg_p.done;
				rdata_sel = seg_p.rdata;
			end
			default: begin
				done_sel = 1'b0;
				rdata_sel = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			req_q <= '0;
		end else begin
			req_q <= '0;
			case (state_q)
				IDLE: begin
					if (accept) begin
						if (|region_hit) begin
							state_q <= ACCESS;
							req_q <= region_hit;
						end else begin
							state_q <= RESPOND; // Error, no peripheral cycle
						end
					end
				end
				ACCESS: if (done_sel) state_q <= RESPOND;
				RESPOND: if (rsp_ready_i) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= req_addr_i;
			we_q <= req_we_i;
			wdata_q <= req_wdata_i;
			sel_q <= req_sel_i;
			rsp_err_q <= !(|region_hit);
			rsp_rdata_q <= '0;
		end else if (state_q == ACCESS && done_sel) begin
			rsp_rdata_q <= we_q ? '0 : rdata_sel;
		end
	end

	assign offset = {{(32 - REGION_LSB){1'b0}}, addr_q[REGION_LSB-1:0]};

	assign rom_p.req = req_q[0];
	assign rom_p.we = we_q;
	assign rom_p.offset = offset;
	assign rom_p.wdata = wdata_q;
	assign rom_p.sel = sel_q;

	assign ram_p.req = req_q[1];
	assign ram_p.we = we_q;
	assign ram_p.offset = offset;
	assign ram_p.wdata = wdata_q;
	assign ram_p.sel = sel_q;

	assign uart_p.req = req_q[2];
	assign uart_p.we = we_q;
	assign uart_p.offset = offset;
	assign uart_p.wdata = wdata_q;
	assign uart_p.sel = sel_q;

	assign seg_p.req = req_q[3];
	assign seg_p.we = we_q;
	assign seg_p.offset = offset;
	assign seg_p.wdata = wdata_q;
	assign seg_p.sel = sel_q;

	assign req_ready_o = state_q == IDLE;
	assign rsp_valid_o = state_q == RESPOND;
	assign rsp_rdata_o = rsp_rdata_q;
	assign rsp_err_o = rsp_err_q;

	a_one_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0({rom_p.req, ram_p.req, uart_p.req, seg_p.req}));

	// Response stays put until taken
	a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o)
			&& $stable(rsp_err_o));

endmodule

`default_nettype wire

// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0]  bus_sel_t;

	// Top address nibble picks the peripheral
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 28;

	typedef logic [REGION_MSB-REGION_LSB:0] region_t;

	localparam region_t REGION_ROM  = 4'd0;
	localparam region_t REGION_RAM  = 4'd1;
	localparam region_t REGION_UART = 4'd2;
	localparam region_t REGION_SEG  = 4'd3; // 4..15 unmapped

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: design/periph_if.sv
`timescale 1ns/10ps
`default_nettype none

interface periph_if import bus_pkg::*; ();

	logic      req;    // Single cycle strobe
	logic      we;
	bus_addr_t offset; // Address with region bits cleared
	bus_data_t wdata;
	bus_sel_t  sel;
	bus_data_t rdata;
	logic      done;   // Single cycle, rdata valid with it

	modport ctrl (
		output req, we, offset, wdata, sel,
		input  rdata, done
	);

	modport periph (
		input  req, we, offset, wdata, sel,
		output rdata, done
	);

endinterface

`default_nettype wire

// File: design/periph_pkg.sv
`default_nettype none

package periph_pkg;

	localparam int RAM_WORDS = 256;
	typedef logic [$clog2(RAM_WORDS)-1:0] ram_index_t; // offset bits 9:2

	localparam int ROM_WORDS = 16;
	typedef logic [$clog2(ROM_WORDS)-1:0] rom_index_t; // offset bits 5:2

	// Kept short for simulation
	localparam int UART_CLKS_PER_BIT = 8;

	localparam int UART_DATA_OFS = 0;
	localparam int UART_STAT_OFS = 4;

	// Segments a..g in bits 6..0, low lights the segment
	typedef logic [6:0] seg_t;

	localparam seg_t SEG_HEX [16] = '{
		7'h01, 7'h4F, 7'h12, 7'h06,
		7'h4C, 7'h24, 7'h20, 7'h0F,
		7'h00, 7'h04, 7'h08, 7'h60,
		7'h31, 7'h42, 7'h30, 7'h38
	};

endpackage

`default_nettype wire

// File: design/seg_display.sv
`timescale 1ns/10ps
`default_nettype none

module seg_display import periph_pkg::*; (
	input  logic     clk,
	input  logic     rst_n_i,
	output seg_t     seg_o,
	periph_if.periph bus_p
);

	logic [3:0] digit_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			digit_q <= 4'h0;
			bus_p.done <= 1'b0;
		end else begin
			bus_p.done <= bus_p.req;
			if (bus_p.req && bus_p.we) digit_q <= bus_p.wdata[3:0];
		end
	end

	assign bus_p.rdata = {28'h0, digit_q};
	assign seg_o = SEG_HEX[digit_q]; // Active low pattern

endmodule

`default_nettype wire

// File: design/soc_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_bus_top import bus_pkg::*, periph_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      req_valid_i,
	input  bus_addr_t req_addr_i,
	input  logic      req_we_i,
	input  bus_data_t req_wdata_i,
	input  bus_sel_t  req_sel_i,
	input  logic      rsp_ready_i,
	output logic      req_ready_o,
	output logic      rsp_valid_o,
	output bus_data_t rsp_rdata_o,
	output logic      rsp_err_o,
	output logic      uart_txd_o,
	output seg_t      seg_o
);

	periph_if rom_if ();
	periph_if ram_if ();
	periph_if uart_if ();
	periph_if seg_if ();

	bus_ctrl bus_ctrl_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.req_valid_i (req_valid_i),
		.req_addr_i  (req_addr_i),
		.req_we_i    (req_we_i),
		.req_wdata_i (req_wdata_i),
		.req_sel_i   (req_sel_i),
		.rsp_ready_i (rsp_ready_i),
		.req_ready_o (req_ready_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_rdata_o (rsp_rdata_o),
		.rsp_err_o   (rsp_err_o),
		.rom_p       (rom_if),
		.ram_p       (ram_if),
		.uart_p      (uart_if),
		.seg_p       (seg_if)
	);

	boot_rom boot_rom_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.bus_p   (rom_if)
	);

	word_ram word_ram_i (
		.clk   (clk),
		.bus_p (ram_if)
	);

	uart_tx uart_tx_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.txd_o   (uart_txd_o),
		.bus_p   (uart_if)
	);

	seg_display seg_display_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.seg_o   (seg_o),
		.bus_p   (seg_if)
	);

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx import periph_pkg::*; (
	input  logic     clk,
	input  logic     rst_n_i,
	output logic     txd_o,
	periph_if.periph bus_p
);

	localparam int CNT_W = $clog2(UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(UART_CLKS_PER_BIT - 1);
	localparam logic [3:0] LAST_BIT = 4'd9; // Stop bit

	logic             busy_q;
	logic             pend_q; // Write waiting for the frame to end
	logic [CNT_W-1:0] cnt_q;
	logic [3:0]       bit_q;
	logic [8:0]       shift_q;
	logic [7:0]       tx_byte_q;
	logic             is_data;
	logic             is_stat;
	logic             data_wr;
	logic             bit_end;
	logic             frame_end;
	logic             load;
	logic [7:0]       load_byte;

	assign is_data = bus_p.offset[3:0] == 4'(UART_DATA_OFS);
	assign is_stat = bus_p.offset[3:0] == 4'(UART_STAT_OFS);
	assign data_wr = bus_p.req && bus_p.we && is_data;
	assign bit_end = busy_q && cnt_q == CNT_LAST;
	assign frame_end = bit_end && bit_q == LAST_BIT;
	assign load = (data_wr || pend_q) && (!busy_q || frame_end);
	assign load_byte = pend_q ? tx_byte_q : bus_p.wdata[7:0];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			pend_q <= 1'b0;
			cnt_q <= '0;
			bit_q <= '0;
			txd_o <= 1'b1;
			bus_p.done <= 1'b0;
		end else begin
			bus_p.done <= 1'b0;
			if (load) begin
				busy_q <= 1'b1;
				pend_q <= 1'b0;
				cnt_q <= '0;
				bit_q <= '0;
				txd_o <= 1'b0; // Start bit
				bus_p.done <= 1'b1;
			end else if (frame_end) begin
				busy_q <= 1'b0;
				txd_o <= 1'b1;
			end else if (bit_end) begin
				cnt_q <= '0;
				bit_q <= bit_q + 4'd1;
				txd_o <= shift_q[0];
			end else if (busy_q) begin
				cnt_q <= cnt_q + 1'b1;
			end
			if (data_wr && !load) pend_q <= 1'b1;
			if (bus_p.req && !data_wr) bus_p.done <= 1'b1;
		end
	end

	// Data bits LSB first with the stop bit shifting in behind
	always_ff @(posedge clk) begin
		if (load) begin
			shift_q <= {1'b1, load_byte};
		end else if (bit_end) begin
			shift_q <= {1'b1, shift_q[8:1]};
		end
		if (data_wr) tx_byte_q <= bus_p.wdata[7:0];
		if (bus_p.req && !bus_p.we) begin
			bus_p.rdata <= is_stat ? {31'h0, busy_q} : {24'h0, tx_byte_q};
		end
	end

	a_idle_high: assert property (@(posedge clk) disable iff (!rst_n_i)
		!busy_q |-> txd_o);

endmodule

`default_nettype wire

// File: design/word_ram.sv
`timescale 1ns/10ps
`default_nettype none

module word_ram import bus_pkg::*, periph_pkg::*; (
	input logic      clk,
	periph_if.periph bus_p
);

	bus_data_t  mem_q [RAM_WORDS];
	ram_index_t idx;

	// Upper offset bits ignored, RAM aliases
	assign idx = bus_p.offset[9:2];

	always_ff @(posedge clk) begin
		bus_p.done <= bus_p.req;
		if (bus_p.req) begin
			bus_p.rdata <= mem_q[idx];
			if (bus_p.we) begin
				for (int i = 0; i < 4; i++) begin
					if (bus_p.sel[i]) begin
						mem_q[idx][i*8 +: 8] <= bus_p.wdata[i*8 +: 8];
					end
				end
			end
		end
	end

	a_done_after_req: assert property (@(posedge clk)
		bus_p.done |-> $past(bus_p.req));

endmodule

`default_nettype wire

// File: filelist.f
design/bus_pkg.sv
design/periph_pkg.sv
design/periph_if.sv
design/bus_ctrl.sv
design/word_ram.sv
design/boot_rom.sv
design/uart_tx.sv
design/seg_display.sv
design/soc_bus_top.sv
test/clk_gen.sv
test/tb_soc_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bus testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_soc_bus -f filelist.f \
	--Mdir obj_dir -o tb_soc_bus > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat "$build_log"
	echo "verilator build returned status $build_status"
	exit 1
fi

./obj_dir/tb_soc_bus > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
	echo "simulation returned status $sim_status"
	exit 1
fi

if grep -q "test failed" "$sim_log"; then
	exit 1
fi
exit 0

// File: test/bus_stimulus.txt
name op addr data sel exp_rdata exp_err
ram_wr_full0 W 10000000 12345678 f 00000000 0
ram_wr_full1 W 10000004 cafef00d f 00000000 0
ram_rd_full0 R 10000000 00000000 f 12345678 0
ram_rd_full1 R 10000004 00000000 f cafef00d 0
ram_wr_lane0 W 10000000 aabbccdd 1 00000000 0
ram_rd_lane0 R 10000000 00000000 f 123456dd 0
ram_wr_lane23 W 10000004 11223344 c 00000000 0
ram_rd_lane23 R 10000004 00000000 f 1122f00d 0
ram_wr_fill2 W 10000008 ffffffff f 00000000 0
ram_wr_lane12 W 10000008 00000000 6 00000000 0
ram_rd_lane12 R 10000008 00000000 f ff0000ff 0
ram_rd_alias R 10000400 00000000 f 123456dd 0
rom_rd_0 R 00000000 00000000 f 3c081000 0
rom_rd_4 R 00000010 00000000 f 3c0b2000 0
rom_rd_14 R 00000038 00000000 f 1000ffff 0
rom_rd_15 R 0000003c 00000000 f 00000000 0
rom_rd_alias R 00000040 00000000 f 3c081000 0
rom_wr W 00000004 deadbeef f 00000000 1
rom_rd_1 R 00000004 00000000 f 34090055 0
unmap_rd R 40000000 00000000 f 00000000 1
unmap_wr W f0000010 12345678 f 00000000 1
ram_after_err R 10000004 00000000 f 1122f00d 0
uart_wr_0 W 20000000 00000055 1 00000000 0
uart_wr_1 W 20000000 000000a3 1 00000000 0
uart_stat R 20000004 00000000 f 00000001 0
uart_data R 20000000 00000000 f 000000a3 0
seg_wr_7 W 30000000 00000007 f 00000000 0
seg_rd_7 R 30000000 00000000 f 00000007 0
seg_wr_b W 30000000 0000000b f 00000000 0
seg_rd_b R 30000000 00000000 f 0000000b 0
seg_wr_e W 30000000 0000002e f 00000000 0
seg_rd_e R 30000000 00000000 f 0000000e 0

// File: test/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD = 10; // 20 ns clock
	localparam int RESET_CYCLES = 3;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#2 rst_n_o = 1'b1; // Released off the edge
	end

endmodule

`default_nettype wire

// File: test/tb_soc_bus.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc_bus;

	localparam int TIMEOUT = 200;
	localparam int BIT_CLKS = 8; // UART bit time in clocks

	logic        clk;
	logic        rst_n;
	logic        req_valid;
	logic [31:0] req_addr;
	logic        req_we;
	logic [31:0] req_wdata;
	logic [3:0]  req_sel;
	logic        rsp_ready;
	logic        req_ready;
	logic        rsp_valid;
	logic [31:0] rsp_rdata;
	logic        rsp_err;
	logic        uart_txd;
	logic [6:0]  seg;

	integer      seed;
	logic        test_ok;
	logic        timed_out;
	int          pass_count;
	int          fail_count;
	logic [7:0]  uart_sent [$];
	logic [7:0]  uart_rx [$];
	logic        uart_line_err;
	logic        mon_active;
	int          mon_cnt;
	int          mon_bit;
	logic [7:0]  mon_byte;

	clk_gen clk_gen_i (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	soc_bus_top soc_bus_top_i (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.req_valid_i (req_valid),
		.req_addr_i  (req_addr),
		.req_we_i    (req_we),
		.req_wdata_i (req_wdata),
		.req_sel_i   (req_sel),
		.rsp_ready_i (rsp_ready),
		.req_ready_o (req_ready),
		.rsp_valid_o (rsp_valid),
		.rsp_rdata_o (rsp_rdata),
		.rsp_err_o   (rsp_err),
		.uart_txd_o  (uart_txd),
		.seg_o       (seg)
	);

	// Active-low a..g pattern with segment a in bit 6
	function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
		logic [6:0] lit;
		case (digit)
			4'h0: lit = 7'b1111110;
			4'h1: lit = 7'b0110000;
			4'h2: lit = 7'b1101101;
			4'h3: lit = 7'b1111001;
			4'h4: lit = 7'b0110011;
			4'h5: lit = 7'b1011011;
			4'h6: lit = 7'b1011111;
			4'h7: lit = 7'b1110000;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1111011;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b0011111;
			4'hC: lit = 7'b1001110;
			4'hD: lit = 7'b0111101;
			4'hE: lit = 7'b1001111;
			default: lit = 7'b1000111;
		endcase
		return ~lit;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error %0s: expected %h, actual %h", what, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic report_test(input string tname);
		if (test_ok) begin
			pass_count++;
			$display("ok   %0s", tname);
		end else begin
			fail_count++;
			$display("FAIL %0s", tname);
		end
	endtask

	task automatic run_access(input string tname, input logic is_wr, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] sel, input logic [31:0] exp_rdata,
			input logic exp_err);
		int cycles;
		int hold;
		logic [31:0] held_rdata;
		test_ok = 1'b1;
		req_valid = 1'b1;
		req_addr = addr;
		req_we = is_wr;
		req_wdata = wdata;
		req_sel = sel;
		cycles = 0;
		while (req_ready !== 1'b1 && cycles < TIMEOUT) begin
			step_cycle();
			cycles++;
		end
		if (req_ready !== 1'b1) begin
			$display("%0s: the request was never accepted", tname);
			timed_out = 1'b1;
		end else begin
			step_cycle(); // Request transfers here
			req_valid = 1'b0;
			cycles = 0;
			while (rsp_valid !== 1'b1 && cycles < TIMEOUT) begin
				step_cycle();
				cycles++;
			end
			if (rsp_valid !== 1'b1) begin
				$display("%0s: no response arrived", tname);
				timed_out = 1'b1;
			end else begin
				held_rdata = rsp_rdata;
				hold = $random(seed) & 3;
				repeat (hold) begin
					step_cycle();
					check_value({tname, " held rsp_valid"}, 32'd1, rsp_valid);
					check_value({tname, " held rdata"}, held_rdata, rsp_rdata);
					check_value({tname, " held req_ready"}, 32'd0, req_ready);
				end
				check_value({tname, " rdata"}, exp_rdata, rsp_rdata);
				check_value({tname, " err"}, exp_err, rsp_err);
				if (is_wr && addr[31:28] == 4'd3) begin
					check_value({tname, " seg"}, seg_pattern(wdata[3:0]), seg);
				end
				// Earlier frames must be out before a data write completes
				if (is_wr && addr == 32'h2000_0000) begin
					check_value({tname, " frames done"}, uart_sent.size(), uart_rx.size());
					uart_sent.push_back(wdata[7:0]);
				end
				rsp_ready = 1'b1;
				step_cycle();
				rsp_ready = 1'b0;
			end
		end
		if (timed_out) test_ok = 1'b0;
	endtask

	// UART line monitor sampling mid bit on the falling edge
	always @(negedge clk) begin
		if (rst_n !== 1'b1) begin
			mon_active = 1'b0;
		end else if (!mon_active) begin
			if (uart_txd === 1'b0) begin
				mon_active = 1'b1;
				mon_cnt = 0;
			end
		end else begin
			mon_cnt++;
			if (mon_cnt % BIT_CLKS == BIT_CLKS / 2) begin
				mon_bit = mon_cnt / BIT_CLKS;
				if (mon_bit == 0) begin
					if (uart_txd !== 1'b0) begin
						$display("UART start bit did not stay low");
						uart_line_err = 1'b1;
						mon_active = 1'b0;
					end
				end else if (mon_bit <= 8) begin
					mon_byte[mon_bit-1] = uart_txd; // LSB first
				end else begin
					if (uart_txd !== 1'b1) begin
						$display("UART stop bit was not high");
						uart_line_err = 1'b1;
					end else begin
						uart_rx.push_back(mon_byte);
					end
					mon_active = 1'b0;
				end
			end
		end
	end

	initial begin
		int fd;
		int n;
		int cycles;
		logic reading;
		logic [8*24-1:0] name_vec;
		logic [8*4-1:0]  op_vec;
		logic [31:0]     addr;
		logic [31:0]     wdata;
		logic [3:0]      sel;
		logic [31:0]     exp_rdata;
		logic            exp_err;
		string           tname;
		req_valid = 1'b0;
		req_addr = '0;
		req_we = 1'b0;
		req_wdata = '0;
		req_sel = '0;
		rsp_ready = 1'b0;
		seed = 3088;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		uart_line_err = 1'b0;
		mon_active = 1'b0;
		mon_cnt = 0;
		mon_bit = 0;
		mon_byte = '0;
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			timed_out = 1'b1;
		end
		step_cycle();

		test_ok = 1'b1;
		check_value("reset_state req_ready", 32'd1, req_ready);
		check_value("reset_state rsp_valid", 32'd0, rsp_valid);
		check_value("reset_state uart_txd", 32'd1, uart_txd);
		check_value("reset_state seg", seg_pattern(4'h0), seg);
		report_test("reset_state");

		fd = $fopen("test/bus_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open test/bus_stimulus.txt");
			fail_count++;
		end else begin
			repeat (7) n = $fscanf(fd, "%s", name_vec); // Column titles
			reading = 1'b1;
			while (reading && !timed_out) begin
				n = $fscanf(fd, "%s %s %h %h %h %h %h", name_vec, op_vec, addr, wdata, sel,
					exp_rdata, exp_err);
				if (n != 7) begin
					reading = 1'b0;
				end else begin
					tname = $sformatf("%0s", name_vec);
					run_access(tname, op_vec == "W", addr, wdata, sel, exp_rdata, exp_err);
					report_test(tname);
				end
			end
			$fclose(fd);
		end

		if (!timed_out) begin
			test_ok = 1'b1;
			cycles = 0;
			while (uart_rx.size() < uart_sent.size() && cycles < 4 * TIMEOUT) begin
				step_cycle();
				cycles++;
			end
			if (uart_rx.size() != uart_sent.size()) begin
				$display("uart_frames: %0d of %0d frames seen on the line",
					uart_rx.size(), uart_sent.size());
				test_ok = 1'b0;
			end else begin
				foreach (uart_sent[i]) begin
					check_value($sformatf("uart_frames byte %0d", i), uart_sent[i], uart_rx[i]);
				end
			end
			if (uart_line_err) test_ok = 1'b0;
			report_test("uart_frames");
		end

		$display("summary: %0d ok, %0d failing", pass_count, fail_count);
		if (fail_count == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
